/* design/cpu_settings.svh */
// Build-time sizes for the decode/execute core.
// Include wherever a width, depth or credit count is needed.

`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Machine word width
`define DATA_W 16

// Architectural registers, register 0 is hardwired to zero
`define NUM_REGS 8

// Instruction queue entries, also the fetch source's starting credits
`define QUEUE_DEPTH 4

// Result records the writeback consumer can accept before returning credit
`define WB_CREDITS 2

`endif

/* design/isa_pkg.sv */
// Instruction set definitions: opcodes, branch conditions, field layout
// and the decoded control word driven by the control unit.

`default_nettype none

`include "cpu_settings.svh"

package isa_pkg;

    localparam int REG_AW = $clog2(`NUM_REGS);

    typedef logic [REG_AW-1:0] reg_addr_t;

    // JAL return address lands here
    localparam reg_addr_t LINK_REG = reg_addr_t'(`NUM_REGS - 1);

    typedef enum logic [4:0] {
        NOP, ADD, SUB, AND, OR, XOR, SHL, SHR, ADDI,
        LDL, LDU, BR, JAL, JR, HALT
    } opcode_e;

    // Carried in the rd field of BR
    typedef enum logic [2:0] {
        EQ, NE, LT, GE, VS, ALWAYS
    } cond_e;

    ////////////////////
    // Instruction formats, all 16 bits wide
    ////////////////////
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [1:0] pad;
    } r_form_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        logic [4:0] imm5;
    } i_form_t;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        logic [7:0] imm8;
    } l_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
        l_form_t l;
    } instr_t;

    typedef struct packed {
        opcode_e alu_op;
        logic    use_imm;
        logic    reads_rs;
        logic    reads_rt;
        logic    writes_rd;
        logic    flags_we;
        logic    load_low;
        logic    load_high;
        logic    branch;
        logic    jump;
        logic    link;
        logic    jump_reg;
        logic    halt;
    } ctrl_t;

endpackage

`default_nettype wire

/* design/pipe_pkg.sv */
// Pipeline traffic types: what the fetch source pushes in and the
// result record the stage hands to writeback.

`default_nettype none

`include "cpu_settings.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flags_t;

    // One queue slot
    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        instr_t             instr;
    } fetch_entry_t;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        opcode_e            opcode;
        logic               we;
        reg_addr_t          dst;
        logic [`DATA_W-1:0] data;
        // Redirect info, fetch decides what to do with it
        logic               taken;
        logic [`DATA_W-1:0] target;
        flags_t             flags;
    } result_t;

endpackage

`default_nettype wire

/* design/instr_queue.sv */
// Circular instruction FIFO between the fetch source and the stage.
// Writes are credit controlled, one credit goes back per dequeue.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instr_queue import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  fetch_entry_t in_entry,
    output logic         in_credit,
    output logic         q_valid,
    output fetch_entry_t q_entry,
    input  logic         q_pop
);

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    fetch_entry_t     mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             full;

    assign q_valid = (count != '0);
    assign q_entry = mem[rd_ptr];
    assign pop     = q_pop && q_valid;
    assign full    = (count == CNT_W'(`QUEUE_DEPTH));

    // Storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    ////////////////////
    // Pointers and occupancy
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
            in_credit <= pop;
        end
    end

    // Source sent without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !full)
        else $error("instr_queue write while full");

endmodule

`default_nettype wire

/* design/control_unit.sv */
// Opcode decode for the decode/execute stage.
// Also remembers that a HALT has issued, until the next reset.

`timescale 1ns/1ps
`default_nettype none

module control_unit import isa_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  opcode_e opcode,
    input  logic    issue,
    output ctrl_t   ctrl,
    output logic    halted
);

    ////////////////////
    // Decode table
    ////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        case (opcode)
            ADD, SUB, AND, OR, XOR, SHL, SHR: begin
                ctrl.alu_op    = opcode;
                ctrl.reads_rs  = 1'b1;
                ctrl.reads_rt  = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.flags_we  = 1'b1;
            end
            ADDI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reads_rs  = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.flags_we  = 1'b1;
            end
            // Old rd comes in on the rs read port
            LDL: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.load_low  = 1'b1;
            end
            LDU: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.writes_rd = 1'b1;
                ctrl.load_high = 1'b1;
            end
            BR:   ctrl.branch = 1'b1;
            JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            JR: begin
                ctrl.jump     = 1'b1;
                ctrl.jump_reg = 1'b1;
                ctrl.reads_rs = 1'b1;
            end
            HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (issue && ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    // The stage must gate issue with halted
    a_no_issue_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !issue)
        else $error("instruction issued after HALT");

endmodule

`default_nettype wire

/* design/register_file.sv */
// General purpose register file, two read ports and one write port.
// Reads are combinational and see the value before this cycle's write.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module register_file import isa_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  reg_addr_t          rs_addr,
    input  reg_addr_t          rt_addr,
    output logic [`DATA_W-1:0] rs_data,
    output logic [`DATA_W-1:0] rt_data,
    input  logic               we,
    input  reg_addr_t          wr_addr,
    input  logic [`DATA_W-1:0] wr_data
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            // Register 0 keeps its reset value
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

/* design/alu.sv */
// Combinational ALU for the decode/execute stage.
// Add, subtract, logic ops and shifts, with Z/N/V for the flags register.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module alu import isa_pkg::*, pipe_pkg::*; (
    input  opcode_e                    op,
    input  logic [`DATA_W-1:0]         a,
    input  logic [`DATA_W-1:0]         b,
    input  logic [$clog2(`DATA_W)-1:0] shamt,
    output logic [`DATA_W-1:0]         result,
    output flags_t                     flags
);

    localparam int MSB = `DATA_W - 1;

    logic ovf;

    always_comb begin
        ovf = 1'b0;
        case (op)
            ADD: begin
                result = a + b;
                ovf    = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
            end
            SUB: begin
                result = a - b;
                // Operand signs differ and the sign flipped
                ovf    = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
            end
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            SHL: result = a << shamt;
            SHR: result = a >> shamt;
            default: result = '0;
        endcase
    end

    assign flags.z = (result == '0);
    assign flags.n = result[MSB];
    assign flags.v = ovf;

endmodule

`default_nettype wire

/* design/branch_unit.sv */
// Next-pc logic: condition check, branch/jump target and link address.
// target is the address after this instruction, whether taken or not.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module branch_unit import isa_pkg::*, pipe_pkg::*; (
    input  ctrl_t              ctrl,
    input  cond_e              cond,
    input  flags_t             flags,
    input  logic [`DATA_W-1:0] pc,
    input  logic [7:0]         offset8,
    input  logic [`DATA_W-1:0] rs_data,
    output logic               taken,
    output logic [`DATA_W-1:0] target,
    output logic [`DATA_W-1:0] link_addr
);

    logic               cond_ok;
    logic [`DATA_W-1:0] offset_ext;
    logic [`DATA_W-1:0] dest;

    always_comb begin
        case (cond)
            EQ:     cond_ok = flags.z;
            NE:     cond_ok = !flags.z;
            LT:     cond_ok = flags.n ^ flags.v;
            GE:     cond_ok = !(flags.n ^ flags.v);
            VS:     cond_ok = flags.v;
            ALWAYS: cond_ok = 1'b1;
            default: cond_ok = 1'b0;
        endcase
    end

    assign link_addr  = pc + `DATA_W'(1);
    assign offset_ext = {{(`DATA_W-8){offset8[7]}}, offset8};
    assign dest       = ctrl.jump_reg ? rs_data : link_addr + offset_ext;

    assign taken  = (ctrl.branch && cond_ok) || ctrl.jump;
    assign target = taken ? dest : link_addr;

endmodule

`default_nettype wire

/* design/decode_execute.sv */
// Decode/execute stage. Issues one queued instruction at a time into a held
// result record, which leaves under downstream credit and writes the
// register file in the same cycle.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module decode_execute import isa_pkg::*, pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         q_valid,
    input  fetch_entry_t q_entry,
    output logic         q_pop,
    output logic         wb_valid,
    output result_t      wb_result,
    input  logic         wb_credit
);

    localparam int CRED_W = $clog2(`WB_CREDITS + 1);

    instr_t             instr;
    opcode_e            opcode;
    ctrl_t              ctrl;
    logic               halted;
    reg_addr_t          rs_addr;
    reg_addr_t          rt_addr;
    reg_addr_t          dst;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;
    logic [`DATA_W-1:0] alu_b;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] load_value;
    logic [`DATA_W-1:0] wr_value;
    logic [`DATA_W-1:0] target;
    logic [`DATA_W-1:0] link_addr;
    flags_t             alu_flags;
    flags_t             flags_q;
    flags_t             flags_next;
    logic               taken;
    logic               hazard;
    logic               issue;
    logic               emit;
    logic               held;
    result_t            res_q;
    logic [CRED_W-1:0]  credits;

    ////////////////////
    // Decode and operands
    ////////////////////
    assign instr  = q_entry.instr;
    assign opcode = instr.r.opcode;

    // LDL/LDU read their own rd to merge into
    assign rs_addr = (ctrl.load_low || ctrl.load_high) ? instr.r.rd : instr.r.rs;
    assign rt_addr = instr.r.rt;
    assign dst     = ctrl.link ? LINK_REG : instr.r.rd;

    control_unit u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (opcode),
        .issue  (issue),
        .ctrl   (ctrl),
        .halted (halted)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (emit && res_q.we),
        .wr_addr (res_q.dst),
        .wr_data (res_q.data)
    );

    assign alu_b = ctrl.use_imm ? {{(`DATA_W-5){instr.i.imm5[4]}}, instr.i.imm5} : rt_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (alu_b[$clog2(`DATA_W)-1:0]),
        .result (alu_result),
        .flags  (alu_flags)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .cond      (cond_e'(instr.r.rd)),
        .flags     (flags_q),
        .pc        (q_entry.pc),
        .offset8   (instr.l.imm8),
        .rs_data   (rs_data),
        .taken     (taken),
        .target    (target),
        .link_addr (link_addr)
    );

    assign load_value = ctrl.load_high ? {instr.l.imm8, rs_data[`DATA_W-9:0]}
                                       : {rs_data[`DATA_W-1:8], instr.l.imm8};

    always_comb begin
        if (!ctrl.writes_rd) begin
            wr_value = '0;
        end else if (ctrl.link) begin
            wr_value = link_addr;
        end else if (ctrl.load_low || ctrl.load_high) begin
            wr_value = load_value;
        end else begin
            wr_value = alu_result;
        end
    end

    assign flags_next = ctrl.flags_we ? alu_flags : flags_q;

    ////////////////////
    // Issue, hazard and handshake
    ////////////////////
    // Held record counts until its write has landed, no bypass path
    assign hazard = held && res_q.we &&
                    ((ctrl.reads_rs && rs_addr == res_q.dst) ||
                     (ctrl.reads_rt && rt_addr == res_q.dst));

    assign emit  = held && (credits != '0);
    assign issue = q_valid && (!held || emit) && !hazard && !halted;

    assign q_pop     = issue;
    assign wb_valid  = emit;
    assign wb_result = res_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held    <= 1'b0;
            flags_q <= '0;
            credits <= CRED_W'(`WB_CREDITS);
        end else begin
            if (issue) begin
                held    <= 1'b1;
                flags_q <= flags_next;
            end else if (emit) begin
                held <= 1'b0;
            end
            credits <= credits - CRED_W'(emit) + CRED_W'(wb_credit);
        end
    end

    // Record payload
    always_ff @(posedge clk) begin
        if (issue) begin
            res_q.pc     <= q_entry.pc;
            res_q.opcode <= opcode;
            res_q.we     <= ctrl.writes_rd;
            res_q.dst    <= dst;
            res_q.data   <= wr_value;
            res_q.taken  <= taken;
            res_q.target <= target;
            res_q.flags  <= flags_next;
        end
    end

    // Sink returned more credit than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(`WB_CREDITS))
        else $error("writeback credit counter above limit");

endmodule

`default_nettype wire

/* design/dex_core.sv */
// Top of the decode/execute core: instruction queue feeding the stage.
// Credit flow control on the fetch side and the writeback side.

`timescale 1ns/1ps
`default_nettype none

module dex_core import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  fetch_entry_t in_entry,
    output logic         in_credit,
    output logic         wb_valid,
    output result_t      wb_result,
    input  logic         wb_credit
);

    logic         q_valid;
    fetch_entry_t q_entry;
    logic         q_pop;

    instr_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_entry  (in_entry),
        .in_credit (in_credit),
        .q_valid   (q_valid),
        .q_entry   (q_entry),
        .q_pop     (q_pop)
    );

    decode_execute u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid   (q_valid),
        .q_entry   (q_entry),
        .q_pop     (q_pop),
        .wb_valid  (wb_valid),
        .wb_result (wb_result),
        .wb_credit (wb_credit)
    );

endmodule

`default_nettype wire

/* test/tb_vectors.svh */
// Program table for the decode/execute testbench, included inside the testbench module.
// Each row is one instruction and the record it should produce. Rows after HALT produce none.

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int          MAX_ROWS = 32;
localparam logic [15:0] PC_BASE  = 16'h0040;

instr_t  vec_instr [MAX_ROWS];
result_t vec_exp   [MAX_ROWS];
int      n_rows;
int      n_emit;

// Instruction encoders, field layout from the ISA
function automatic instr_t enc_r(opcode_e op, int rd, int rs, int rt);
    return instr_t'({op, 3'(rd), 3'(rs), 3'(rt), 2'b00});
endfunction

function automatic instr_t enc_i(opcode_e op, int rd, int rs, logic [4:0] imm5);
    return instr_t'({op, 3'(rd), 3'(rs), imm5});
endfunction

function automatic instr_t enc_l(opcode_e op, int rd, logic [7:0] imm8);
    return instr_t'({op, 3'(rd), imm8});
endfunction

task automatic add_row(instr_t ins, logic we, int dst, logic [15:0] data,
                       logic taken, logic [15:0] target, flags_t fl);
    vec_instr[n_rows]      = ins;
    vec_exp[n_rows].pc     = PC_BASE + 16'(n_rows);
    vec_exp[n_rows].opcode = ins.r.opcode;
    vec_exp[n_rows].we     = we;
    vec_exp[n_rows].dst    = reg_addr_t'(dst);
    vec_exp[n_rows].data   = data;
    vec_exp[n_rows].taken  = taken;
    vec_exp[n_rows].target = target;
    vec_exp[n_rows].flags  = fl;
    n_rows++;
    n_emit++;
endtask

// Falls through to pc+1
task automatic seq_row(instr_t ins, logic we, int dst, logic [15:0] data, flags_t fl);
    add_row(ins, we, dst, data, 1'b0, PC_BASE + 16'(n_rows) + 16'd1, fl);
endtask

// BR carries its condition in the rd field, which shows up as dst
task automatic br_row(cond_e c, logic [7:0] off, logic taken, logic [15:0] target,
                      flags_t fl);
    add_row(enc_l(BR, int'(c), off), 1'b0, int'(c), 16'h0000, taken, target, fl);
endtask

// Queued behind HALT, must never come out
task automatic tail_row(instr_t ins);
    vec_instr[n_rows] = ins;
    vec_exp[n_rows]   = '0;
    n_rows++;
endtask

// Flags are written as {z, n, v}
task automatic fill_vectors();
    n_rows = 0;
    n_emit = 0;
    seq_row(enc_l(LDL, 1, 8'h34), 1'b1, 1, 16'h0034, 3'b000);
    seq_row(enc_l(LDU, 1, 8'h12), 1'b1, 1, 16'h1234, 3'b000);
    seq_row(enc_i(ADDI, 2, 0, 5'd5), 1'b1, 2, 16'h0005, 3'b000);
    seq_row(enc_r(ADD, 3, 1, 2), 1'b1, 3, 16'h1239, 3'b000);
    seq_row(enc_r(SUB, 4, 2, 2), 1'b1, 4, 16'h0000, 3'b100);
    br_row(EQ, 8'h04, 1'b1, 16'h004A, 3'b100);
    br_row(NE, 8'h10, 1'b0, 16'h0047, 3'b100);
    seq_row(enc_i(ADDI, 5, 0, 5'h1F), 1'b1, 5, 16'hFFFF, 3'b010);
    br_row(LT, 8'hFE, 1'b1, 16'h0047, 3'b010);
    br_row(GE, 8'h05, 1'b0, 16'h004A, 3'b010);
    seq_row(enc_l(LDU, 6, 8'h80), 1'b1, 6, 16'h8000, 3'b010);
    // 0x8000 - 0x1234 overflows
    seq_row(enc_r(SUB, 7, 6, 1), 1'b1, 7, 16'h6DCC, 3'b001);
    br_row(VS, 8'h03, 1'b1, 16'h0050, 3'b001);
    seq_row(enc_r(ADD, 7, 6, 6), 1'b1, 7, 16'h0000, 3'b101);
    br_row(ALWAYS, 8'h80, 1'b1, 16'hFFCF, 3'b101);
    seq_row(enc_r(AND, 3, 1, 5), 1'b1, 3, 16'h1234, 3'b000);
    seq_row(enc_r(OR, 4, 1, 2), 1'b1, 4, 16'h1235, 3'b000);
    seq_row(enc_r(XOR, 4, 4, 1), 1'b1, 4, 16'h0001, 3'b000);
    seq_row(enc_r(SHL, 3, 1, 4), 1'b1, 3, 16'h2468, 3'b000);
    seq_row(enc_r(SHR, 3, 5, 2), 1'b1, 3, 16'h07FF, 3'b000);
    // Write to r0 is dropped, the next ADD reads zero
    seq_row(enc_r(ADD, 0, 1, 1), 1'b1, 0, 16'h2468, 3'b000);
    seq_row(enc_r(ADD, 2, 0, 0), 1'b1, 2, 16'h0000, 3'b100);
    add_row(enc_l(JAL, 0, 8'h10), 1'b1, 7, 16'h0057, 1'b1, 16'h0067, 3'b100);
    add_row(enc_r(JR, 0, 7, 0), 1'b0, 0, 16'h0000, 1'b1, 16'h0057, 3'b100);
    seq_row(enc_r(NOP, 0, 0, 0), 1'b0, 0, 16'h0000, 3'b100);
    seq_row(enc_r(HALT, 0, 0, 0), 1'b0, 0, 16'h0000, 3'b100);
    tail_row(enc_i(ADDI, 1, 1, 5'd1));
    tail_row(enc_r(ADD, 2, 1, 1));
endtask

`endif

/* test/tb_dex_core.sv */
// Testbench for dex_core with a credit-limited fetch source, a writeback sink
// with random credit return, and record checks against the program table.

`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_dex_core import isa_pkg::*, pipe_pkg::*; ();

    localparam int QUIET_CYCLES = 20;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         in_valid;
    fetch_entry_t in_entry;
    logic         in_credit;
    logic         wb_valid;
    result_t      wb_result;
    logic         wb_credit;

    int          src_credits;
    int          recv_count;
    int          outstanding;
    int          cycle;
    int          last_due;
    int          owed_due[$];
    logic        halt_seen;
    logic [31:0] rng_state;

    `include "tb_vectors.svh"

    dex_core dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_entry  (in_entry),
        .in_credit (in_credit),
        .wb_valid  (wb_valid),
        .wb_result (wb_result),
        .wb_credit (wb_credit)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string fmt_result(result_t r);
        return $sformatf("pc=%h op=%s we=%b dst=%0d data=%h taken=%b target=%h",
                         r.pc, r.opcode.name(), r.we, r.dst, r.data, r.taken, r.target);
    endfunction

    // Everything except the flags
    task automatic check_result(result_t got, result_t exp, int row);
        result_t g;
        result_t e;
        g       = got;
        e       = exp;
        g.flags = '0;
        e.flags = '0;
        if (g !== e) begin
            abort_run($sformatf("MISMATCH at %0t: record %0d got %s, expected %s",
                                $time, row, fmt_result(got), fmt_result(exp)));
        end
    endtask

    task automatic check_flags(flags_t got, flags_t exp, int row);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: record %0d flags znv=%b, expected %b",
                                $time, row, got, exp));
        end
    endtask

    task automatic check_credit(int count, int lo, int hi, string what);
        if (count < lo || count > hi) begin
            abort_run($sformatf("ERROR at %0t: %s is %0d, outside %0d..%0d",
                                $time, what, count, lo, hi));
        end
    endtask

    ////////////////////
    // Fetch source
    ////////////////////
    initial begin : source
        fetch_entry_t entry;
        int           idx;
        in_valid    = 1'b0;
        in_entry    = '0;
        src_credits = `QUEUE_DEPTH;
        idx         = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (in_credit) begin
                src_credits++;
            end
            if (idx < n_rows && src_credits > 0) begin
                entry.pc    = PC_BASE + 16'(idx);
                entry.instr = vec_instr[idx];
                in_valid    <= 1'b1;
                in_entry    <= entry;
                src_credits--;
                idx++;
            end else begin
                in_valid <= 1'b0;
            end
            check_credit(src_credits, 0, `QUEUE_DEPTH, "source credit count");
        end
    end

    ////////////////////
    // Writeback sink
    ////////////////////
    initial begin : sink
        int due;
        wb_credit   = 1'b0;
        rng_state   = 32'd25086;
        halt_seen   = 1'b0;
        recv_count  = 0;
        outstanding = 0;
        cycle       = 0;
        last_due    = -1;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            cycle++;
            wb_credit <= 1'b0;
            if (wb_valid) begin
                if (recv_count >= n_emit) begin
                    abort_run($sformatf("ERROR at %0t: record for pc %h arrived after HALT",
                                        $time, wb_result.pc));
                end else begin
                    check_result(wb_result, vec_exp[recv_count], recv_count);
                    check_flags(wb_result.flags, vec_exp[recv_count].flags, recv_count);
                    if (vec_exp[recv_count].opcode == HALT) begin
                        halt_seen = 1'b1;
                    end
                    recv_count++;
                    outstanding++;
                    // Credit returns after 0 to 3 cycles and never two in one cycle
                    rng_state = xorshift32(rng_state);
                    due       = cycle + int'(rng_state[1:0]);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    owed_due.push_back(due);
                end
            end
            if (owed_due.size() > 0 && owed_due[0] <= cycle) begin
                void'(owed_due.pop_front());
                wb_credit <= 1'b1;
                outstanding--;
            end
            check_credit(outstanding, 0, `WB_CREDITS, "records awaiting credit return");
        end
    end

    initial begin : watchdog
        wait (n_rows > 0);
        repeat (40 * n_rows) @(posedge clk);
        abort_run($sformatf("ERROR at %0t: timeout, run did not finish within %0d cycles",
                            $time, 40 * n_rows));
    end

    ////////////////////
    // Reset and end of run
    ////////////////////
    initial begin : main
        rst_n = 1'b0;
        fill_vectors();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (halt_seen === 1'b1);
        // Nothing more may leave while the queue still holds the tail rows
        repeat (QUIET_CYCLES) @(posedge clk);
        @(negedge clk);
        // Tail rows stay queued and their credits never return
        if (src_credits == `QUEUE_DEPTH - (n_rows - n_emit)) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run($sformatf("ERROR at %0t: %0d source credits after HALT, expected %0d",
                                $time, src_credits, `QUEUE_DEPTH - (n_rows - n_emit)));
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
+incdir+test
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_queue.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/branch_unit.sv
design/decode_execute.sv
design/dex_core.sv
test/tb_dex_core.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing -j 0
TOP         = tb_dex_core
FILELIST    = tb.f
OBJ_DIR     = obj_dir
PASS_TEXT   = TESTBENCH PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
